// File: rtl/rv_pkg.sv
package rv_pkg;

  localparam int XLEN       = 64;
  localparam int IMEM_WORDS = 64;   // 32-bit words
  localparam int DMEM_WORDS = 32;   // doublewords
  localparam int IMEM_AW    = $clog2(IMEM_WORDS);
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_REG_W  = 7'b0111011;
  localparam logic [6:0] OP_IMM_W  = 7'b0011011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [2:0] F3_LW  = 3'b010;   // also SW
  localparam logic [2:0] F3_LD  = 3'b011;   // also SD
  localparam logic [2:0] F3_LWU = 3'b110;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;   // srl / sra
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  typedef enum logic [1:0] {ALU_ADD, ALU_FUNCT, ALU_BRANCH} alu_op_e;
  typedef enum logic [1:0] {SEXT_NONE, SEXT_WORD, SEXT_SHIFT} sext_e;
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;
  typedef enum logic [1:0] {A_REG, A_PC, A_ZERO} a_sel_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2, rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2, rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2, rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } rv_instr_u;

endpackage

// File: rtl/rv_ctrl_if.sv
`timescale 1ns/100ps

interface rv_ctrl_if
  import rv_pkg::*;
();

  logic       alu_src;        // 0 rs2, 1 imm
  a_sel_e     a_sel;
  alu_op_e    alu_op;
  sext_e      sext;
  logic [2:0] funct3;
  logic       reg_w;
  wb_sel_e    wb_sel;
  logic       mem_r;
  logic       mem_w;
  logic       redirect;       // take branch / jump target
  logic       redirect_reg;   // target is rs1+imm

  modport control (output alu_src, a_sel, alu_op, sext, funct3, reg_w, wb_sel,
                   output mem_r, mem_w, redirect, redirect_reg);
  modport datapath (input alu_src, a_sel, alu_op, sext, funct3, reg_w, wb_sel,
                    input mem_w, redirect, redirect_reg);
  modport memory (input funct3, mem_r, mem_w);

endinterface

// File: rtl/rv_alu.sv
`timescale 1ns/100ps

module rv_alu
  import rv_pkg::*;
(
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  alu_op_e         alu_op,
  input  logic [2:0]      funct3,
  input  logic            funct7_5,
  input  sext_e           sext,
  output logic [XLEN-1:0] result
);

  logic [5:0]      shamt;
  logic [XLEN-1:0] shift_src;
  logic [XLEN-1:0] sra_val;
  logic            sub;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] raw;

  assign shamt = (sext == SEXT_NONE) ? b[5:0] : {1'b0, b[4:0]};   // word ops shift by 5 bits
  assign sub   = (alu_op == ALU_BRANCH) || (alu_op == ALU_FUNCT && funct3 == F3_ADD && funct7_5);
  assign sum   = sub ? a - b : a + b;

  // srlw/sraw shift only the low word, so widen it first
  always_comb begin
    shift_src = a;
    if (sext == SEXT_SHIFT) begin
      shift_src = funct7_5 ? {{(XLEN-32){a[31]}}, a[31:0]} : {{(XLEN-32){1'b0}}, a[31:0]};
    end
  end

  assign sra_val = $signed(shift_src) >>> shamt;

  always_comb begin
    raw = sum;   // add mode and branch compare
    if (alu_op == ALU_FUNCT) begin
      case (funct3)
        F3_SLL:  raw = a << shamt;
        F3_SLT:  raw = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
        F3_SLTU: raw = {{(XLEN-1){1'b0}}, a < b};
        F3_XOR:  raw = a ^ b;
        F3_SR:   raw = funct7_5 ? sra_val : shift_src >> shamt;
        F3_OR:   raw = a | b;
        F3_AND:  raw = a & b;
        default: raw = sum;
      endcase
    end
  end

  assign result = (sext == SEXT_NONE) ? raw : {{(XLEN-32){raw[31]}}, raw[31:0]};

endmodule

// File: rtl/rv_control.sv
`timescale 1ns/100ps

module rv_control
  import rv_pkg::*;
(
  input  rv_instr_u       instr,
  input  logic [XLEN-1:0] rs1_val,
  input  logic [XLEN-1:0] rs2_val,
  rv_ctrl_if.control      ctrl
);

  logic [2:0] f3;
  logic       taken;

  assign f3          = instr.r.funct3;
  assign ctrl.funct3 = f3;

  always_comb begin
    case (f3)
      F3_BEQ:  taken = (rs1_val == rs2_val);
      F3_BNE:  taken = (rs1_val != rs2_val);
      F3_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
      F3_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
      F3_BLTU: taken = (rs1_val < rs2_val);
      F3_BGEU: taken = (rs1_val >= rs2_val);
      default: taken = 1'b0;   // 010 / 011 are not branches
    endcase
  end

  always_comb begin
    ctrl.alu_src      = 1'b0;
    ctrl.a_sel        = A_REG;
    ctrl.alu_op       = ALU_ADD;
    ctrl.sext         = SEXT_NONE;
    ctrl.reg_w        = 1'b0;
    ctrl.wb_sel       = WB_ALU;
    ctrl.mem_r        = 1'b0;
    ctrl.mem_w        = 1'b0;
    ctrl.redirect     = 1'b0;
    ctrl.redirect_reg = 1'b0;
    case (instr.r.opcode)
      OP_LOAD: begin
        ctrl.alu_src = 1'b1;
        ctrl.reg_w   = 1'b1;
        ctrl.wb_sel  = WB_MEM;
        ctrl.mem_r   = 1'b1;
      end
      OP_STORE: begin
        ctrl.alu_src = 1'b1;
        ctrl.mem_w   = 1'b1;
      end
      OP_IMM, OP_REG: begin
        ctrl.alu_src = (instr.r.opcode == OP_IMM);
        ctrl.alu_op  = ALU_FUNCT;
        ctrl.reg_w   = 1'b1;
      end
      OP_IMM_W, OP_REG_W: begin
        ctrl.alu_src = (instr.r.opcode == OP_IMM_W);
        ctrl.alu_op  = ALU_FUNCT;
        ctrl.reg_w   = 1'b1;
        ctrl.sext    = (f3 == F3_SR) ? SEXT_SHIFT : SEXT_WORD;   // srlw/sraw shift 32 bits
      end
      OP_LUI, OP_AUIPC: begin
        ctrl.alu_src = 1'b1;
        ctrl.a_sel   = (instr.r.opcode == OP_LUI) ? A_ZERO : A_PC;
        ctrl.reg_w   = 1'b1;
      end
      OP_JAL, OP_JALR: begin
        ctrl.alu_src      = 1'b1;
        ctrl.a_sel        = (instr.r.opcode == OP_JAL) ? A_PC : A_REG;
        ctrl.reg_w        = 1'b1;
        ctrl.wb_sel       = WB_LINK;
        ctrl.redirect     = 1'b1;
        ctrl.redirect_reg = (instr.r.opcode == OP_JALR);
      end
      OP_BRANCH: begin
        ctrl.alu_op   = ALU_BRANCH;
        ctrl.redirect = taken;
      end
      default: begin
        ctrl.reg_w = 1'b0;   // unknown opcode behaves as a nop
      end
    endcase
  end

endmodule

// File: rtl/rv_imm_gen.sv
`timescale 1ns/100ps

module rv_imm_gen
  import rv_pkg::*;
(
  input  rv_instr_u       instr,
  output logic [XLEN-1:0] imm
);

  always_comb begin
    case (instr.r.opcode)
      OP_LOAD, OP_IMM, OP_IMM_W, OP_JALR: begin
        imm = {{(XLEN-12){instr.i.imm[11]}}, instr.i.imm};
      end
      OP_STORE: begin
        imm = {{(XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
      end
      OP_BRANCH: begin
        imm = {{(XLEN-12){instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
               instr.b.imm_4_1, 1'b0};
      end
      OP_LUI, OP_AUIPC: begin
        imm = {{(XLEN-32){instr.u.imm[19]}}, instr.u.imm, 12'b0};
      end
      OP_JAL: begin
        imm = {{(XLEN-20){instr.j.imm_20}}, instr.j.imm_19_12, instr.j.imm_11,
               instr.j.imm_10_1, 1'b0};
      end
      default: begin
        imm = '0;   // r-type and unknown
      end
    endcase
  end

endmodule

// File: rtl/rv_datapath.sv
`timescale 1ns/100ps

module rv_datapath
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            run,
  input  logic [XLEN-1:0] pc,
  input  rv_instr_u       instr,
  input  logic [XLEN-1:0] imm,
  rv_ctrl_if.datapath     ctrl,
  input  logic [XLEN-1:0] mem_rdata,
  output logic [XLEN-1:0] rs1_val,
  output logic [XLEN-1:0] rs2_val,
  output logic [XLEN-1:0] next_pc,
  output logic [XLEN-1:0] mem_addr,
  output logic [XLEN-1:0] mem_wdata,
  output logic            retire_valid,
  output logic [XLEN-1:0] retire_pc,
  output logic [31:0]     retire_instr,
  output logic            retire_rd_we,
  output logic [4:0]      retire_rd,
  output logic [XLEN-1:0] retire_rd_data,
  output logic            retire_mem_we,
  output logic [XLEN-1:0] retire_mem_addr,
  output logic [XLEN-1:0] retire_mem_data
);

  logic [XLEN-1:0] regs [1:31];   // x0 is not stored
  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] link;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] wb_data;
  logic            funct7_5;
  logic            rd_we;

  assign rs1_val = (instr.r.rs1 == 5'd0) ? '0 : regs[instr.r.rs1];
  assign rs2_val = (instr.r.rs2 == 5'd0) ? '0 : regs[instr.r.rs2];

  assign alu_a = (ctrl.a_sel == A_PC) ? pc : (ctrl.a_sel == A_ZERO) ? '0 : rs1_val;
  assign alu_b = ctrl.alu_src ? imm : rs2_val;
  // immediate forms only take bit 30 as sra select
  assign funct7_5 = instr.r.funct7[5] & (~ctrl.alu_src | (ctrl.funct3 == F3_SR));

  rv_alu u_alu (
    .a(alu_a), .b(alu_b), .alu_op(ctrl.alu_op), .funct3(ctrl.funct3),
    .funct7_5(funct7_5), .sext(ctrl.sext), .result(alu_result)
  );

  assign link    = pc + 64'd4;
  assign target  = ctrl.redirect_reg ? {alu_result[XLEN-1:1], 1'b0} : pc + imm;   // jalr clears bit 0
  assign next_pc = ctrl.redirect ? target : link;
  assign wb_data = (ctrl.wb_sel == WB_MEM) ? mem_rdata :
                   (ctrl.wb_sel == WB_LINK) ? link : alu_result;
  assign rd_we     = ctrl.reg_w & (instr.r.rd != 5'd0);
  assign mem_addr  = alu_result;
  assign mem_wdata = rs2_val;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (run && rd_we) begin
      regs[instr.r.rd] <= wb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retire_valid  <= 1'b0;
      retire_rd_we  <= 1'b0;
      retire_mem_we <= 1'b0;
    end else begin
      retire_valid  <= run;
      retire_rd_we  <= run & rd_we;
      retire_mem_we <= run & ctrl.mem_w;
    end
  end

  always_ff @(posedge clk) begin   // trace payload
    if (run) begin
      retire_pc       <= pc;
      retire_instr    <= instr;
      retire_rd       <= instr.r.rd;
      retire_rd_data  <= wb_data;
      retire_mem_addr <= mem_addr;
      retire_mem_data <= mem_wdata;
    end
  end

endmodule

// File: rtl/rv_fetch.sv
`timescale 1ns/100ps

module rv_fetch
  import rv_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               run,
  input  logic               prog_we,
  input  logic [IMEM_AW-1:0] prog_addr,   // word address
  input  logic [31:0]        prog_data,
  input  logic [XLEN-1:0]    next_pc,
  output logic [XLEN-1:0]    pc,
  output rv_instr_u          instr
);

  logic [31:0] imem [IMEM_WORDS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (run) begin
      pc <= next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (prog_we && !run) begin   // loading only while held
      imem[prog_addr] <= prog_data;
    end
  end

  // zero word past the end decodes as a nop
  assign instr = (pc[XLEN-1:2] < IMEM_WORDS) ? imem[pc[IMEM_AW+1:2]] : 32'd0;

endmodule

// File: rtl/rv_dmem.sv
`timescale 1ns/100ps

module rv_dmem
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            run,
  rv_ctrl_if.memory       ctrl,
  input  logic [XLEN-1:0] addr,
  input  logic [XLEN-1:0] wdata,
  output logic [XLEN-1:0] rdata
);

  logic [XLEN-1:0]    mem [DMEM_WORDS];
  logic [DMEM_AW-1:0] idx;
  logic               in_range;
  logic [XLEN-1:0]    dword;
  logic [31:0]        word;
  logic [XLEN-1:0]    merged;

  assign idx      = addr[DMEM_AW+2:3];
  assign in_range = (addr[XLEN-1:3] < DMEM_WORDS);
  assign dword    = in_range ? mem[idx] : '0;
  assign word     = addr[2] ? dword[XLEN-1:32] : dword[31:0];   // addr bit 2 picks the half

  always_comb begin
    if (!ctrl.mem_r) begin
      rdata = '0;
    end else if (ctrl.funct3 == F3_LD) begin
      rdata = dword;
    end else if (ctrl.funct3 == F3_LWU) begin
      rdata = {{(XLEN-32){1'b0}}, word};
    end else begin
      rdata = {{(XLEN-32){word[31]}}, word};
    end
  end

  always_comb begin
    merged = dword;
    if (ctrl.funct3 == F3_LD) begin
      merged = wdata;
    end else if (addr[2]) begin
      merged[XLEN-1:32] = wdata[31:0];
    end else begin
      merged[31:0] = wdata[31:0];
    end
  end

  always_ff @(posedge clk) begin
    if (run && ctrl.mem_w && in_range) begin
      mem[idx] <= merged;
    end
  end

endmodule

// File: rtl/rv_core_top.sv
`timescale 1ns/100ps

module rv_core_top
  import rv_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               run,
  input  logic               prog_we,
  input  logic [IMEM_AW-1:0] prog_addr,
  input  logic [31:0]        prog_data,
  output logic               retire_valid,
  output logic [XLEN-1:0]    retire_pc,
  output logic [31:0]        retire_instr,
  output logic               retire_rd_we,
  output logic [4:0]         retire_rd,
  output logic [XLEN-1:0]    retire_rd_data,
  output logic               retire_mem_we,
  output logic [XLEN-1:0]    retire_mem_addr,
  output logic [XLEN-1:0]    retire_mem_data
);

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] next_pc;
  rv_instr_u       instr;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] mem_addr;
  logic [XLEN-1:0] mem_wdata;
  logic [XLEN-1:0] mem_rdata;

  rv_ctrl_if ctrl_if ();

  rv_fetch u_fetch (
    .clk, .rst_n, .run,
    .prog_we, .prog_addr, .prog_data,
    .next_pc, .pc, .instr
  );

  rv_control u_control (.instr, .rs1_val, .rs2_val, .ctrl(ctrl_if.control));

  rv_imm_gen u_imm_gen (.instr, .imm);

  rv_datapath u_datapath (
    .clk, .rst_n, .run, .pc, .instr, .imm,
    .ctrl(ctrl_if.datapath), .mem_rdata,
    .rs1_val, .rs2_val, .next_pc, .mem_addr, .mem_wdata,
    .retire_valid, .retire_pc, .retire_instr,
    .retire_rd_we, .retire_rd, .retire_rd_data,
    .retire_mem_we, .retire_mem_addr, .retire_mem_data
  );

  rv_dmem u_dmem (
    .clk, .run, .ctrl(ctrl_if.memory),
    .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
  );

endmodule

// File: verification/tb_model.svh
typedef struct packed {
  logic [63:0] pc;
  logic [31:0] instr;
  logic        rd_we;
  logic [4:0]  rd;
  logic [63:0] rd_data;
  logic        mem_we;
  logic [63:0] mem_addr;
  logic [63:0] mem_data;
} trace_t;

logic [31:0] prog [$];
trace_t      expected [$];
logic [31:0] lfsr_state;
logic [63:0] mregs [32];   // model register file
logic [63:0] mmem [32];    // model data memory, doublewords
logic [63:0] mpc;

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                      input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                      input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// galois lfsr, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int k = 0; k < n; k++) begin
    v = {v[30:0], lfsr_state[0]};
    lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
  end
  return v;
endfunction

function automatic logic [11:0] rand12();
  logic [31:0] v;
  v = rand_bits(12);
  return v[11:0];
endfunction

function automatic logic [19:0] rand20();
  logic [31:0] v;
  v = rand_bits(20);
  return v[19:0];
endfunction

task automatic emit(input logic [31:0] w);
  prog.push_back(w);
endtask

// lui + addiw load a sign-extended 32-bit value whose sign the caller picks
task automatic load_rand32(input logic [4:0] rd, input logic neg);
  logic [31:0] v;
  logic [19:0] hi;
  v     = rand_bits(31);
  v[31] = neg;
  hi    = v[31:12] + {19'b0, v[11]};   // undo the sign of the low 12 bits
  emit(enc_u(hi, rd, OP_LUI));
  emit(enc_i(v[11:0], rd, F3_ADD, rd, OP_IMM_W));
endtask

// branch over one marker instruction
task automatic branch_skip(input logic [2:0] f3, input logic [4:0] rs1, rs2);
  emit(enc_b(13'd8, rs2, rs1, f3));
  emit(enc_i(12'd1, 5'd7, F3_ADD, 5'd7, OP_IMM));
endtask

task automatic build_program();
  lfsr_state = 32'd50;
  prog.delete();
  load_rand32(5'd1, 1'b0);
  load_rand32(5'd2, 1'b1);
  emit(enc_i(12'd32, 5'd1, F3_SLL, 5'd3, OP_IMM));
  emit(enc_r(7'h00, 5'd2, 5'd3, F3_XOR, 5'd3, OP_REG));   // x3 negative in both words
  emit(enc_r(7'h00, 5'd2, 5'd3, F3_ADD, 5'd4, OP_REG));
  emit(enc_r(7'h20, 5'd1, 5'd3, F3_ADD, 5'd5, OP_REG));   // sub
  emit(enc_r(7'h20, 5'd2, 5'd3, F3_SR, 5'd6, OP_REG));    // sra
  emit(enc_r(7'h00, 5'd1, 5'd3, F3_SR, 5'd7, OP_REG));
  emit(enc_r(7'h00, 5'd2, 5'd3, F3_SLL, 5'd8, OP_REG));
  emit(enc_r(7'h00, 5'd1, 5'd3, F3_SLT, 5'd9, OP_REG));
  emit(enc_r(7'h00, 5'd1, 5'd3, F3_SLTU, 5'd10, OP_REG));
  emit(enc_r(7'h00, 5'd2, 5'd1, F3_XOR, 5'd11, OP_REG));
  emit(enc_r(7'h00, 5'd3, 5'd1, F3_OR, 5'd12, OP_REG));
  emit(enc_r(7'h00, 5'd3, 5'd2, F3_AND, 5'd13, OP_REG));
  emit(enc_i(rand12(), 5'd3, F3_ADD, 5'd14, OP_IMM));
  emit(enc_i(rand12(), 5'd3, F3_SLT, 5'd15, OP_IMM));
  emit(enc_i(rand12(), 5'd1, F3_SLTU, 5'd16, OP_IMM));
  emit(enc_i(rand12(), 5'd3, F3_XOR, 5'd17, OP_IMM));
  emit(enc_i(rand12(), 5'd3, F3_OR, 5'd18, OP_IMM));
  emit(enc_i(rand12(), 5'd3, F3_AND, 5'd19, OP_IMM));
  emit(enc_i(12'd13, 5'd3, F3_SLL, 5'd20, OP_IMM));
  emit(enc_i(12'd7, 5'd3, F3_SR, 5'd21, OP_IMM));
  emit(enc_i(12'h428, 5'd3, F3_SR, 5'd22, OP_IMM));       // srai by 40
  emit(enc_r(7'h00, 5'd1, 5'd3, F3_ADD, 5'd0, OP_REG));   // write to x0 is dropped
  emit(enc_r(7'h00, 5'd0, 5'd0, F3_OR, 5'd23, OP_REG));
  emit(enc_r(7'h00, 5'd1, 5'd3, F3_ADD, 5'd24, OP_REG_W));
  emit(enc_r(7'h20, 5'd2, 5'd3, F3_ADD, 5'd25, OP_REG_W));
  emit(enc_r(7'h00, 5'd1, 5'd3, F3_SR, 5'd26, OP_REG_W));
  emit(enc_r(7'h20, 5'd2, 5'd3, F3_SR, 5'd27, OP_REG_W));
  emit(enc_i(rand12(), 5'd3, F3_ADD, 5'd28, OP_IMM_W));
  emit(enc_i(12'h409, 5'd3, F3_SR, 5'd29, OP_IMM_W));     // sraiw by 9
  emit(enc_i(12'd64, 5'd0, F3_ADD, 5'd30, OP_IMM));
  emit(enc_s(12'd8, 5'd3, 5'd30, F3_LD));
  emit(enc_i(12'd8, 5'd30, F3_LD, 5'd31, OP_LOAD));
  emit(enc_s(12'd20, 5'd3, 5'd30, F3_LW));                // upper half of dword 10
  emit(enc_i(12'd20, 5'd30, F3_LW, 5'd4, OP_LOAD));
  emit(enc_i(12'd20, 5'd30, F3_LWU, 5'd5, OP_LOAD));
  emit(enc_s(12'd16, 5'd1, 5'd30, F3_LW));
  emit(enc_i(12'd16, 5'd30, F3_LW, 5'd6, OP_LOAD));
  branch_skip(F3_BEQ, 5'd1, 5'd2);
  branch_skip(F3_BNE, 5'd1, 5'd2);
  branch_skip(F3_BLT, 5'd3, 5'd1);
  branch_skip(F3_BGE, 5'd3, 5'd1);
  branch_skip(F3_BLTU, 5'd3, 5'd1);
  branch_skip(F3_BGEU, 5'd3, 5'd1);
  branch_skip(F3_BEQ, 5'd2, 5'd2);
  emit(enc_u(rand20(), 5'd8, OP_AUIPC));
  emit(enc_u(rand20(), 5'd9, OP_LUI));
  emit(enc_j(21'd8, 5'd10));
  emit(enc_i(12'd1, 5'd7, F3_ADD, 5'd7, OP_IMM));         // skipped by jal
  emit(enc_u(20'd0, 5'd11, OP_AUIPC));
  emit(enc_i(12'd13, 5'd11, F3_ADD, 5'd12, OP_JALR));     // odd target, lands 12 past auipc
  emit(enc_i(12'd1, 5'd7, F3_ADD, 5'd7, OP_IMM));
  emit(enc_j(21'd0, 5'd0));                               // halt loop
endtask

function automatic logic [63:0] sext32(input logic [31:0] v);
  return {{32{v[31]}}, v};
endfunction

function automatic logic [63:0] alu64(input logic [2:0] f3, input logic alt,
                                      input logic [63:0] a, b);
  case (f3)
    3'b000: return alt ? a - b : a + b;
    3'b001: return a << b[5:0];
    3'b010: return {63'd0, $signed(a) < $signed(b)};
    3'b011: return {63'd0, a < b};
    3'b100: return a ^ b;
    3'b101: begin
      if (alt) begin
        return $signed(a) >>> b[5:0];
      end
      return a >> b[5:0];
    end
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic [63:0] aluw(input logic [2:0] f3, input logic alt,
                                     input logic [63:0] a, b);
  logic [31:0] r;
  case (f3)
    3'b001: r = a[31:0] << b[4:0];
    3'b101: begin
      if (alt) begin
        r = $signed(a[31:0]) >>> b[4:0];
      end else begin
        r = a[31:0] >> b[4:0];
      end
    end
    default: r = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
  endcase
  return sext32(r);
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [63:0] a, b);
  case (f3)
    3'b000: return a == b;
    3'b001: return a != b;
    3'b100: return $signed(a) < $signed(b);
    3'b101: return $signed(a) >= $signed(b);
    3'b110: return a < b;
    default: return a >= b;
  endcase
endfunction

// executes one instruction on the model state
task automatic model_step(output trace_t t);
  logic [31:0] w;
  logic [6:0]  op;
  logic [2:0]  f3;
  logic [4:0]  rd;
  logic [63:0] a, b, imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [63:0] res, npc, addr, d;
  logic        we, alt;
  w     = prog[mpc[7:2]];
  op    = w[6:0];
  f3    = w[14:12];
  rd    = w[11:7];
  a     = mregs[w[19:15]];
  b     = mregs[w[24:20]];
  imm_i = {{52{w[31]}}, w[31:20]};
  imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
  imm_b = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  imm_u = {{32{w[31]}}, w[31:12], 12'b0};
  imm_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  t       = '0;
  t.pc    = mpc;
  t.instr = w;
  t.rd    = rd;
  npc     = mpc + 64'd4;
  res     = '0;
  we      = 1'b0;
  alt     = w[30] && (op == OP_REG || op == OP_REG_W || f3 == 3'b101);
  case (op)
    OP_REG: begin
      res = alu64(f3, alt, a, b);
      we  = 1'b1;
    end
    OP_IMM: begin
      res = alu64(f3, alt, a, imm_i);
      we  = 1'b1;
    end
    OP_REG_W: begin
      res = aluw(f3, alt, a, b);
      we  = 1'b1;
    end
    OP_IMM_W: begin
      res = aluw(f3, alt, a, imm_i);
      we  = 1'b1;
    end
    OP_LUI: begin
      res = imm_u;
      we  = 1'b1;
    end
    OP_AUIPC: begin
      res = mpc + imm_u;
      we  = 1'b1;
    end
    OP_JAL: begin
      res = mpc + 64'd4;
      we  = 1'b1;
      npc = mpc + imm_j;
    end
    OP_JALR: begin
      res = mpc + 64'd4;
      we  = 1'b1;
      npc = (a + imm_i) & ~64'd1;
    end
    OP_BRANCH: begin
      if (branch_taken(f3, a, b)) begin
        npc = mpc + imm_b;
      end
    end
    OP_LOAD: begin
      addr = a + imm_i;
      d    = mmem[addr[7:3]];
      we   = 1'b1;
      if (f3 == 3'b011) begin
        res = d;
      end else if (f3 == 3'b110) begin
        res = {32'd0, addr[2] ? d[63:32] : d[31:0]};
      end else begin
        res = sext32(addr[2] ? d[63:32] : d[31:0]);
      end
    end
    OP_STORE: begin
      addr       = a + imm_s;
      t.mem_we   = 1'b1;
      t.mem_addr = addr;
      t.mem_data = b;
      if (f3 == 3'b011) begin
        mmem[addr[7:3]] = b;
      end else if (addr[2]) begin
        mmem[addr[7:3]][63:32] = b[31:0];
      end else begin
        mmem[addr[7:3]][31:0] = b[31:0];
      end
    end
    default: ;
  endcase
  if (we && rd != 5'd0) begin
    mregs[rd]  = res;
    t.rd_we    = 1'b1;
    t.rd_data  = res;
  end
  mpc = npc;
endtask

task automatic run_model();
  trace_t t;
  mpc = '0;
  foreach (mregs[i]) begin
    mregs[i] = '0;
  end
  foreach (mmem[i]) begin
    mmem[i] = '0;
  end
  expected.delete();
  do begin
    model_step(t);
    expected.push_back(t);
  end while (t.instr != enc_j(21'd0, 5'd0) && expected.size() < 200);
endtask

// File: verification/tb_core.sv
`timescale 1ns/100ps

module tb_core
  import rv_pkg::*;
();

  logic               clk = 1'b0;
  logic               rst_n;
  logic               run;
  logic               prog_we;
  logic [IMEM_AW-1:0] prog_addr;
  logic [31:0]        prog_data;
  logic               retire_valid;
  logic [XLEN-1:0]    retire_pc;
  logic [31:0]        retire_instr;
  logic               retire_rd_we;
  logic [4:0]         retire_rd;
  logic [XLEN-1:0]    retire_rd_data;
  logic               retire_mem_we;
  logic [XLEN-1:0]    retire_mem_addr;
  logic [XLEN-1:0]    retire_mem_data;

  `include "tb_model.svh"

  trace_t rec;
  int     rec_idx;
  int     run_cycles;
  int     cycle_limit;
  logic   expect_valid;   // rst_n and run as seen at the last edge

  rv_core_top UUT (
    .clk, .rst_n, .run, .prog_we, .prog_addr, .prog_data,
    .retire_valid, .retire_pc, .retire_instr,
    .retire_rd_we, .retire_rd, .retire_rd_data,
    .retire_mem_we, .retire_mem_addr, .retire_mem_data
  );

  always #5 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [63:0] exp_val, act_val);
    $display("Fail %s: expected %h, got %h", name, exp_val, act_val);
    $display("Test FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  initial begin
    rst_n        = 1'b0;
    run          = 1'b0;
    prog_we      = 1'b0;
    prog_addr    = '0;
    prog_data    = '0;
    expect_valid = 1'b0;
    rec_idx      = 0;
    run_cycles   = 0;
    build_program();
    run_model();
    cycle_limit = 4 * expected.size();
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    foreach (prog[i]) begin   // core held while the program goes in
      @(posedge clk);
      #1;
      prog_we   = 1'b1;
      prog_addr = IMEM_AW'(i);
      prog_data = prog[i];
    end
    @(posedge clk);
    #1 prog_we = 1'b0;
    repeat (3) @(posedge clk);
    #1 run = 1'b1;
  end

  always @(posedge clk) begin
    expect_valid <= rst_n && run;
    if (run) begin
      run_cycles <= run_cycles + 1;
    end
  end

  always @(negedge clk) begin
    if (run_cycles > cycle_limit) begin
      $display("Timeout: program did not reach its last instruction in %0d cycles",
               cycle_limit);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end
  end

  // outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    assert (retire_valid === expect_valid)
      else report_mismatch("retire_valid", 64'(expect_valid), 64'(retire_valid));
    if (retire_valid === 1'b1) begin
      rec     = expected[rec_idx];
      rec_idx = rec_idx + 1;
      assert (retire_pc === rec.pc)
        else report_mismatch("retire_pc", rec.pc, retire_pc);
      assert (retire_instr === rec.instr)
        else report_mismatch("retire_instr", 64'(rec.instr), 64'(retire_instr));
      assert (retire_rd_we === rec.rd_we)
        else report_mismatch("retire_rd_we", 64'(rec.rd_we), 64'(retire_rd_we));
      if (rec.rd_we) begin
        assert (retire_rd === rec.rd)
          else report_mismatch("retire_rd", 64'(rec.rd), 64'(retire_rd));
        assert (retire_rd_data === rec.rd_data)
          else report_mismatch("retire_rd_data", rec.rd_data, retire_rd_data);
      end
      assert (retire_mem_we === rec.mem_we)
        else report_mismatch("retire_mem_we", 64'(rec.mem_we), 64'(retire_mem_we));
      if (rec.mem_we) begin   // payload only means something on a store
        assert (retire_mem_addr === rec.mem_addr)
          else report_mismatch("retire_mem_addr", rec.mem_addr, retire_mem_addr);
        assert (retire_mem_data === rec.mem_data)
          else report_mismatch("retire_mem_data", rec.mem_data, retire_mem_data);
      end
      if (rec_idx == expected.size()) begin
        $display("Test OK");
        $finish;
      end
    end
  end

endmodule

// File: project.f
+incdir+verification
rtl/rv_pkg.sv
rtl/rv_ctrl_if.sv
rtl/rv_alu.sv
rtl/rv_control.sv
rtl/rv_imm_gen.sv
rtl/rv_datapath.sv
rtl/rv_fetch.sv
rtl/rv_dmem.sv
rtl/rv_core_top.sv
verification/tb_core.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= project.f
TOP       ?= tb_core
RTL_TOP   ?= rv_core_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
